//--- program_input.txt
# P addr instr = program word, D addr word = initial data
# S addr data = expected store, in order
P 80000000 800000B7
P 80000004 20008093
P 80000008 06400113
P 8000000C FF900193
P 80000010 00310233
P 80000014 0040A023
P 80000018 403102B3
P 8000001C 0050A223
P 80000020 00314333
P 80000024 0060A423
P 80000028 0021A3B3
P 8000002C 0021B433
P 80000030 0070A623
P 80000034 0080A823
P 80000038 4011D493
P 8000003C 0041D513
P 80000040 00311593
P 80000044 0090AA23
P 80000048 00A0AC23
P 8000004C 00B0AE23
P 80000050 0F016613
P 80000054 0FF1F693
P 80000058 12345737
P 8000005C 00001797
P 80000060 02C0A023
P 80000064 02D0A223
P 80000068 02E0A423
P 8000006C 02F0A623
P 80000070 00210463
P 80000074 0230A823
P 80000078 00311463
P 8000007C 0230A823
P 80000080 0021C463
P 80000084 0230A823
P 80000088 0021D463
P 8000008C 0270A823
P 80000090 00316463
P 80000094 0230A823
P 80000098 00317463
P 8000009C 0220AA23
P 800000A0 0080086F
P 800000A4 0230A823
P 800000A8 0300AC23
P 800000AC 015808E7
P 800000B0 0230A823
P 800000B4 0230A823
P 800000B8 0310AE23
P 800000BC 1000A903
P 800000C0 1040A983
P 800000C4 01390A33
P 800000C8 0540A023
P 800000CC 1000A003
P 800000D0 00510013
P 800000D4 0400A223
P 800000D8 0520A423
P 800000DC 00100073
D 80000300 11111111
D 80000304 22223333
S 80000200 0000005D
S 80000204 0000006B
S 80000208 FFFFFF9D
S 8000020C 00000001
S 80000210 00000000
S 80000214 FFFFFFFC
S 80000218 0FFFFFFF
S 8000021C 00000320
S 80000220 000000F4
S 80000224 000000F9
S 80000228 12345000
S 8000022C 8000105C
S 80000230 00000001
S 80000234 00000064
S 80000238 800000A4
S 8000023C 800000B0
S 80000240 33334444
S 80000244 00000000
S 80000248 11111111

//--- rv_core.f
rv_core_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_decoder.sv
rv_control.sv
rv_core.sv
rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then decide pass or fail from the log
verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
    -o sim_rv_core > build.log 2>&1 \
    && ./obj_dir/sim_rv_core > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

//--- rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam int                 period       = 40;
    localparam rv_core_pkg::xlen_t start_pc     = 32'h8000_0000;
    localparam int                 halt_timeout = 5000;  // cycles
    localparam int                 req_timeout  = 10;
    localparam int                 mem_words    = 256;

    logic                 clk;
    logic                 reset;
    rv_core_pkg::wb_req_t wb_req;
    rv_core_pkg::wb_rsp_t wb_rsp;
    logic                 halted;

    rv_core_pkg::xlen_t mem [0:mem_words-1];
    rv_core_pkg::xlen_t exp_adr [$];
    rv_core_pkg::xlen_t exp_dat [$];
    logic [31:0]        lfsr_state;
    int                 reset_errs;
    int                 store_errs;
    int                 stable_errs;
    int                 halt_errs;
    int                 tests_passed;
    int                 tests_failed;

    rv_core #(
        .reset_pc(start_pc)
    ) DUT (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic in_memory(input rv_core_pkg::xlen_t adr);
        return adr[31:10] == start_pc[31:10];
    endfunction

    task automatic load_image(output bit ok);
        int    fd;
        int    n;
        string line;
        byte   tag;
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (start_pc + 32'(i * 4)) ^ 32'ha5a5_a5a5;  // fill from full address
        end
        fd = $fopen("program_input.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", tag, a, d);
                    if (n == 3 && (tag == "P" || tag == "D")) begin
                        mem[a[9:2]] = d;
                    end else if (n == 3 && tag == "S") begin
                        exp_adr.push_back(a);
                        exp_dat.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // checks one write against the next expected store
    task automatic check_store(input rv_core_pkg::wb_req_t req);
        rv_core_pkg::xlen_t ea;
        rv_core_pkg::xlen_t ed;
        if (exp_adr.size() == 0) begin
            $display("store to %h with data %h was not expected", req.adr, req.dat);
            store_errs++;
        end else begin
            ea = exp_adr.pop_front();
            ed = exp_dat.pop_front();
            if (req.adr !== ea) begin
                $display("Mismatch wb_req.adr: got %h expected %h", req.adr, ea);
                store_errs++;
            end
            if (req.dat !== ed) begin
                $display("Mismatch wb_req.dat: got %h expected %h", req.dat, ed);
                store_errs++;
            end
        end
    endtask

    // bus slave with random wait states
    initial begin
        rv_core_pkg::wb_req_t snap;
        logic                 busy;
        int                   wait_left;
        wb_rsp     = '0;
        busy       = 1'b0;
        wait_left  = 0;
        snap       = '0;
        lfsr_state = 32'h1e6a688e;
        forever begin
            @(posedge clk);
            #2;
            if (reset) begin
                wb_rsp.ack = 1'b0;
                busy       = 1'b0;
            end else begin
                if (wb_rsp.ack) begin  // master took the ack at this edge
                    wb_rsp.ack = 1'b0;
                    busy       = 1'b0;
                end
                if (!busy && wb_req.cyc && wb_req.stb) begin
                    busy      = 1'b1;
                    snap      = wb_req;
                    wait_left = {next_random_bit(), next_random_bit()};
                end else if (busy && wb_req !== snap) begin
                    $display("Mismatch wb_req: got %h expected %h", wb_req, snap);
                    stable_errs++;
                end
                if (busy && wait_left == 0) begin
                    if (!in_memory(snap.adr)) begin
                        $display("access to %h lies outside the memory model", snap.adr);
                        store_errs++;
                        wb_rsp.dat = '0;
                    end else if (snap.we) begin
                        check_store(snap);
                        mem[snap.adr[9:2]] = snap.dat;
                    end else begin
                        wb_rsp.dat = mem[snap.adr[9:2]];
                    end
                    wb_rsp.ack = 1'b1;
                end else if (busy) begin
                    wait_left--;
                end
            end
        end
    end

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        int  count;
        logic seen;
        bit  image_ok;
        reset        = 1'b1;
        reset_errs   = 0;
        store_errs   = 0;
        stable_errs  = 0;
        halt_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_image(image_ok);

        if (!image_ok) begin
            $display("could not open program_input.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            repeat (2) begin
                @(posedge clk);
                #1;
                if (wb_req.cyc !== 1'b0 || wb_req.stb !== 1'b0) begin
                    $display("Mismatch wb_req.cyc/stb: got %h/%h expected 0/0",
                             wb_req.cyc, wb_req.stb);
                    reset_errs++;
                end
            end
            #1 reset = 1'b0;

            seen  = 1'b0;
            count = 0;
            while (!seen && count < req_timeout) begin
                @(posedge clk);
                #1;
                count++;
                seen = wb_req.cyc;
            end
            if (!seen) begin
                $display("no bus request appeared after reset");
                reset_errs++;
            end else begin
                if (wb_req.adr !== start_pc) begin
                    $display("Mismatch wb_req.adr: got %h expected %h", wb_req.adr, start_pc);
                    reset_errs++;
                end
                if (wb_req.we !== 1'b0) begin
                    $display("Mismatch wb_req.we: got %h expected %h", wb_req.we, 1'b0);
                    reset_errs++;
                end
            end
            report("reset", reset_errs);

            count = 0;
            while (halted !== 1'b1 && count < halt_timeout) begin
                @(posedge clk);
                #1;
                count++;
            end
            if (halted !== 1'b1) begin
                $display("timeout, halted never rose");
                $display("Testbench failed");
                $finish;
            end else begin
                report("program stores", store_errs);
                report("request stability", stable_errs);
                for (int i = 0; i < 20; i++) begin
                    @(posedge clk);
                    #1;
                    if (wb_req.cyc !== 1'b0 || wb_req.stb !== 1'b0) begin
                        $display("bus request made while halted");
                        halt_errs++;
                    end
                end
                if (exp_adr.size() != 0) begin
                    $display("%0d expected stores never happened", exp_adr.size());
                    halt_errs++;
                end
                report("halt", halt_errs);
                $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
                if (tests_failed == 0) begin
                    $display("Testbench passed");
                end else begin
                    $display("Testbench failed");
                end
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
    parameter rv_core_pkg::xlen_t reset_pc = 32'h8000_0000
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    output rv_core_pkg::wb_req_t      wb_req,
    input  wire rv_core_pkg::wb_rsp_t wb_rsp,
    output logic                      halted
);

    rv_core_pkg::xlen_t    inst;
    rv_core_pkg::decoded_t dec;
    rv_core_pkg::xlen_t    rdata1;
    rv_core_pkg::xlen_t    rdata2;
    rv_core_pkg::xlen_t    alu_a;
    rv_core_pkg::xlen_t    alu_b;
    rv_core_pkg::xlen_t    alu_result;
    logic                  branch_taken;
    logic                  rf_we;
    rv_core_pkg::reg_idx_t rf_waddr;
    rv_core_pkg::xlen_t    rf_wdata;

    rv_control #(
        .reset_pc(reset_pc)
    ) u_control (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .dec          (dec),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .halted       (halted)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    rv_alu u_alu (
        .alu_op       (dec.alu_op),
        .a            (alu_a),
        .b            (alu_b),
        .result       (alu_result),
        .funct3       (dec.funct3),
        .rs1_val      (rdata1),
        .rs2_val      (rdata2),
        .branch_taken (branch_taken)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

`default_nettype wire

//--- rv_control.sv
`timescale 1ns/10ps
`default_nettype none

module rv_control #(
    parameter rv_core_pkg::xlen_t reset_pc = 32'h8000_0000
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output rv_core_pkg::xlen_t         inst,
    input  wire rv_core_pkg::decoded_t dec,
    input  wire rv_core_pkg::xlen_t    rdata1,
    input  wire rv_core_pkg::xlen_t    rdata2,
    output rv_core_pkg::xlen_t         alu_a,
    output rv_core_pkg::xlen_t         alu_b,
    input  wire rv_core_pkg::xlen_t    alu_result,
    input  wire logic                  branch_taken,
    output logic                       rf_we,
    output rv_core_pkg::reg_idx_t      rf_waddr,
    output rv_core_pkg::xlen_t         rf_wdata,
    output rv_core_pkg::wb_req_t       wb_req,
    input  wire rv_core_pkg::wb_rsp_t  wb_rsp,
    output logic                       halted
);

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halt
    } state_t;

    state_t             state;
    rv_core_pkg::xlen_t pc;
    rv_core_pkg::xlen_t pc_plus4;
    rv_core_pkg::xlen_t pc_next;
    logic               fetch_done;
    logic               is_load;
    logic               is_store;
    logic               is_link;    // jal or jalr
    logic               is_ebreak;
    logic               writes_rd;  // execute-stage write-back

    assign pc_plus4   = pc + 32'd4;
    assign fetch_done = (state == st_fetch) && wb_req.cyc && wb_rsp.ack;

    assign is_load  = (dec.inst_class == rv_core_pkg::class_i) &&
                      (dec.opcode == rv_core_pkg::opc_load);
    assign is_store = (dec.inst_class == rv_core_pkg::class_s);
    assign is_link  = (dec.inst_class == rv_core_pkg::class_j) ||
                      ((dec.inst_class == rv_core_pkg::class_i) &&
                       (dec.opcode == rv_core_pkg::opc_jalr));
    assign is_ebreak = (dec.opcode == rv_core_pkg::opc_system) &&
                       (dec.funct3 == rv_core_pkg::f3_priv) &&
                       (dec.imm == rv_core_pkg::ebreak_imm);

    assign writes_rd = (dec.inst_class == rv_core_pkg::class_r) ||
                       (dec.inst_class == rv_core_pkg::class_u) ||
                       (dec.inst_class == rv_core_pkg::class_j) ||
                       ((dec.inst_class == rv_core_pkg::class_i) && !is_load);

    always_comb begin
        alu_a = rdata1;
        alu_b = dec.imm;
        unique case (dec.inst_class)
            rv_core_pkg::class_r,
            rv_core_pkg::class_n: alu_b = rdata2;
            rv_core_pkg::class_u: alu_a = (dec.opcode == rv_core_pkg::opc_lui) ? '0 : pc;
            rv_core_pkg::class_b,
            rv_core_pkg::class_j: alu_a = pc;  // target = pc + imm
            default: ;
        endcase
    end

    always_comb begin
        pc_next = pc_plus4;
        if (dec.inst_class == rv_core_pkg::class_j) begin
            pc_next = alu_result;
        end else if (is_link) begin
            pc_next = {alu_result[31:1], 1'b0};  // jalr clears bit 0
        end else if (dec.inst_class == rv_core_pkg::class_b && branch_taken) begin
            pc_next = alu_result;
        end
    end

    always_comb begin
        rf_waddr = dec.rd;
        rf_we    = 1'b0;
        rf_wdata = alu_result;
        if (state == st_memory) begin
            rf_we    = wb_rsp.ack && !wb_req.we;  // load data on ack
            rf_wdata = wb_rsp.dat;
        end else if (state == st_execute) begin
            rf_we = writes_rd;
            if (is_link) begin
                rf_wdata = pc_plus4;
            end
        end
        if (dec.rd == '0) begin
            rf_we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst <= wb_rsp.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_fetch;
            pc         <= reset_pc;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
        end else begin
            unique case (state)
                st_fetch: begin
                    if (!wb_req.cyc) begin  // start the fetch request
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we  <= 1'b0;
                        wb_req.adr <= pc;
                    end else if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state      <= st_execute;
                    end
                end
                st_execute: begin
                    if (is_ebreak) begin
                        state <= st_halt;
                    end else begin
                        pc         <= pc_next;
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        if (is_load || is_store) begin
                            wb_req.we  <= is_store;
                            wb_req.adr <= alu_result;  // rs1 + imm
                            wb_req.dat <= rdata2;
                            state      <= st_memory;
                        end else begin
                            wb_req.we  <= 1'b0;
                            wb_req.adr <= pc_next;
                            state      <= st_fetch;
                        end
                    end
                end
                st_memory: begin
                    if (wb_rsp.ack) begin  // release the bus, fetch follows
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                        state      <= st_fetch;
                    end
                end
                default: ;  // halted until reset
            endcase
        end
    end

    assign halted = (state == st_halt);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc);

    // master holds the whole request through wait states
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        wb_req.cyc && !wb_rsp.ack |=> $stable(wb_req));

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !wb_req.cyc && !wb_req.stb);

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
    input  wire rv_core_pkg::xlen_t inst,
    output rv_core_pkg::decoded_t   dec
);

    rv_core_pkg::opcode_t     opcode;
    rv_core_pkg::funct3_t     funct3;
    rv_core_pkg::inst_class_t inst_class;
    rv_core_pkg::alu_op_t     alu_op;
    rv_core_pkg::xlen_t       imm;
    logic                     bit30;

    assign opcode = rv_core_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];  // sub and sra select

    always_comb begin
        unique case (opcode)
            rv_core_pkg::opc_op:     inst_class = rv_core_pkg::class_r;
            rv_core_pkg::opc_op_imm: inst_class = rv_core_pkg::class_i;
            rv_core_pkg::opc_load:
                inst_class = (funct3 == rv_core_pkg::f3_word) ? rv_core_pkg::class_i
                                                              : rv_core_pkg::class_n;
            rv_core_pkg::opc_store:
                inst_class = (funct3 == rv_core_pkg::f3_word) ? rv_core_pkg::class_s
                                                              : rv_core_pkg::class_n;
            rv_core_pkg::opc_jalr:
                inst_class = (funct3 == rv_core_pkg::f3_jalr) ? rv_core_pkg::class_i
                                                              : rv_core_pkg::class_n;
            rv_core_pkg::opc_branch:  // 010 and 011 are not branches
                inst_class = (funct3[2:1] == 2'b01) ? rv_core_pkg::class_n
                                                    : rv_core_pkg::class_b;
            rv_core_pkg::opc_lui,
            rv_core_pkg::opc_auipc:  inst_class = rv_core_pkg::class_u;
            rv_core_pkg::opc_jal:    inst_class = rv_core_pkg::class_j;
            // system writes nothing, control spots ebreak by its fields
            default:                 inst_class = rv_core_pkg::class_n;
        endcase
    end

    always_comb begin
        unique case (opcode)
            rv_core_pkg::opc_op_imm,
            rv_core_pkg::opc_load,
            rv_core_pkg::opc_jalr,
            rv_core_pkg::opc_system: imm = {{20{inst[31]}}, inst[31:20]};
            rv_core_pkg::opc_store:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_core_pkg::opc_branch:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_core_pkg::opc_lui,
            rv_core_pkg::opc_auipc:  imm = {inst[31:12], 12'b0};
            rv_core_pkg::opc_jal:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:                 imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_core_pkg::alu_add;  // addresses and jump targets
        if (inst_class == rv_core_pkg::class_r ||
            (inst_class == rv_core_pkg::class_i && opcode == rv_core_pkg::opc_op_imm)) begin
            unique case (funct3)
                3'b000: alu_op = (inst_class == rv_core_pkg::class_r && bit30)
                                 ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
                3'b001: alu_op = rv_core_pkg::alu_sll;
                3'b010: alu_op = rv_core_pkg::alu_slt;
                3'b011: alu_op = rv_core_pkg::alu_sltu;
                3'b100: alu_op = rv_core_pkg::alu_xor;
                3'b101: alu_op = bit30 ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                3'b110: alu_op = rv_core_pkg::alu_or;
                default: alu_op = rv_core_pkg::alu_and;
            endcase
        end
    end

    assign dec = '{
        opcode:     opcode,
        funct3:     funct3,
        rd:         inst[11:7],
        rs1:        inst[19:15],
        rs2:        inst[24:20],
        imm:        imm,
        inst_class: inst_class,
        alu_op:     alu_op
    };

endmodule

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
    input  wire rv_core_pkg::alu_op_t alu_op,
    input  wire rv_core_pkg::xlen_t   a,
    input  wire rv_core_pkg::xlen_t   b,
    output rv_core_pkg::xlen_t        result,
    input  wire rv_core_pkg::funct3_t funct3,
    input  wire rv_core_pkg::xlen_t   rs1_val,
    input  wire rv_core_pkg::xlen_t   rs2_val,
    output logic                      branch_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shift amount

    always_comb begin
        unique case (alu_op)
            rv_core_pkg::alu_add:  result = a + b;
            rv_core_pkg::alu_sub:  result = a - b;
            rv_core_pkg::alu_sll:  result = a << shamt;
            rv_core_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::alu_sltu: result = {31'b0, a < b};
            rv_core_pkg::alu_xor:  result = a ^ b;
            rv_core_pkg::alu_srl:  result = a >> shamt;
            rv_core_pkg::alu_sra:  result = $signed(a) >>> shamt;
            rv_core_pkg::alu_or:   result = a | b;
            default:               result = a & b;
        endcase
    end

    // compares register values while the adder forms the target
    always_comb begin
        unique case (funct3)
            rv_core_pkg::f3_beq:  branch_taken = rs1_val == rs2_val;
            rv_core_pkg::f3_bne:  branch_taken = rs1_val != rs2_val;
            rv_core_pkg::f3_blt:  branch_taken = $signed(rs1_val) < $signed(rs2_val);
            rv_core_pkg::f3_bge:  branch_taken = $signed(rs1_val) >= $signed(rs2_val);
            rv_core_pkg::f3_bltu: branch_taken = rs1_val < rs2_val;
            rv_core_pkg::f3_bgeu: branch_taken = rs1_val >= rs2_val;
            default:              branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  wire logic                  clk,
    input  wire logic                  we,
    input  wire rv_core_pkg::reg_idx_t waddr,
    input  wire rv_core_pkg::xlen_t    wdata,
    input  wire rv_core_pkg::reg_idx_t raddr1,
    input  wire rv_core_pkg::reg_idx_t raddr2,
    output rv_core_pkg::xlen_t         rdata1,
    output rv_core_pkg::xlen_t         rdata2
);

    rv_core_pkg::xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 reads zero
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // control filters rd == 0 before it reaches here
    a_no_x0_write: assert property (@(posedge clk) we |-> waddr != '0);

endmodule

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] xlen_t;     // data and address word
    typedef logic [4:0]  reg_idx_t;  // register index
    typedef logic [2:0]  funct3_t;

    // major opcodes the core executes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        class_r,
        class_i,
        class_s,
        class_b,
        class_u,
        class_j,
        class_n  // no-op, no write-back
    } inst_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;
    localparam funct3_t f3_word = 3'b010;  // lw and sw
    localparam funct3_t f3_jalr = 3'b000;
    localparam funct3_t f3_priv = 3'b000;  // ecall/ebreak group

    localparam xlen_t ebreak_imm = 32'h0000_0001;

    typedef struct packed {
        opcode_t     opcode;
        funct3_t     funct3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        xlen_t       imm;
        inst_class_t inst_class;
        alu_op_t     alu_op;
    } decoded_t;

    // wishbone classic, word only
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        xlen_t adr;
        xlen_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        xlen_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
